// ==== verilog/spi_pkg.sv ====
/* SPI master shared definitions */
package spi_pkg;

  localparam int SSW  = 8;   // slave select width
  localparam int SDW  = 8;   // serial byte
  localparam int CDW  = 32;  // command data word
  localparam int DIVW = 8;   // clock divider

  // register map, 4 to 7 undefined
  localparam logic [2:0] ADR_CFG = 3'd0;
  localparam logic [2:0] ADR_STS = 3'd1;  // {rxv, busy}
  localparam logic [2:0] ADR_DAT = 3'd2;  // tx on write, rx on read
  localparam logic [2:0] ADR_CTL = 3'd3;  // write launches a command

  // bus width, 2 and 3 both run quad
  typedef logic [1:0] iom_t;
  localparam iom_t IOM_SGL = 2'd0;
  localparam iom_t IOM_DUA = 2'd1;

  typedef struct packed {
    logic            ien;  // irq enable
    logic [2:0]      ssi;  // slave select index
    logic [DIVW-1:0] div;  // sclk half period is div+1 clocks
  } cfg_t;

  typedef struct packed {
    logic       ssh;  // hold select after last byte
    logic       die;  // data in, read in dual/quad
    iom_t       iom;
    logic [1:0] cnt;  // bytes minus one
  } cmo_ctl_t;

  typedef struct packed {
    cmo_ctl_t       ctl;
    logic [CDW-1:0] dat;
  } cmo_t;

  // serializer queue items
  typedef struct packed {
    logic [SDW-1:0] dat;
    iom_t           iom;
    logic           die;
    logic           ssh;
    logic           lst;  // final byte of command
  } que_o_t;

  typedef struct packed {
    logic [SDW-1:0] dat;
    logic           lst;
  } que_i_t;

  typedef logic [CDW-1:0] cmi_t;  // received word

endpackage

// ==== verilog/spi_regs.sv ====
/* SPI register block */
module spi_regs (
  input  logic          clk,
  input  logic          rst_i,
  // cpu register bus
  input  logic          reg_wen_i,
  input  logic          reg_ren_i,
  input  logic [2:0]    reg_adr_i,
  input  logic [31:0]   reg_wdt_i,
  output logic [31:0]   reg_rdt_o,
  output logic          reg_wrq_o,   // wait request
  output logic          reg_err_o,
  output logic          reg_irq_o,
  // serializer side
  output spi_pkg::cfg_t cfg_o,
  input  logic          busy_i,
  // command out
  output logic          cmo_vld_o,
  output spi_pkg::cmo_t cmo_o,
  input  logic          cmo_rdy_i,
  // command in
  input  logic          cmi_vld_i,
  input  spi_pkg::cmi_t cmi_i,
  output logic          cmi_rdy_o
);

  import spi_pkg::*;

  logic [CDW-1:0] dat_q;  // tx word for next command
  cmi_t           rxd_q;  // last received word
  logic           rxv_q;  // rx word waiting
  logic           busy;
  logic           wr_cfg;
  logic           wr_dat;
  logic           wr_ctl;
  logic           rd_dat;

  assign wr_cfg = reg_wen_i & (reg_adr_i == ADR_CFG);
  assign wr_dat = reg_wen_i & (reg_adr_i == ADR_DAT);
  assign wr_ctl = reg_wen_i & (reg_adr_i == ADR_CTL) & ~cmo_vld_o;
  assign rd_dat = reg_ren_i & (reg_adr_i == ADR_DAT);

  // ctl write stalls while previous command not taken yet
  assign reg_wrq_o = reg_wen_i & (reg_adr_i == ADR_CTL) & cmo_vld_o;
  assign reg_irq_o = rxv_q & cfg_o.ien;

  // pending, in flight, or word parked in rpi behind an empty rx slot
  assign busy = cmo_vld_o | busy_i | (cmi_vld_i & ~rxv_q);

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cfg_o <= '0;
    end else if (wr_cfg) begin
      cfg_o <= reg_wdt_i[$bits(cfg_t)-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_dat) begin
      dat_q <= reg_wdt_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cmo_vld_o <= 1'b0;
      cmo_o.ctl <= '0;
    end else begin
      if (cmo_vld_o & cmo_rdy_i) begin
        cmo_vld_o <= 1'b0;  // taken by rpo
      end
      if (wr_ctl) begin
        cmo_vld_o <= 1'b1;
        cmo_o.ctl <= reg_wdt_i[$bits(cmo_ctl_t)-1:0];
        cmo_o.dat <= dat_q;  // snapshot, sw may reload DAT now
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // receive side and read back
  ////////////////////////////////////////////////////////////

  assign cmi_rdy_o = ~rxv_q;  // one word deep

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rxv_q <= 1'b0;
    end else begin
      if (rd_dat) rxv_q <= 1'b0;
      if (cmi_vld_i & cmi_rdy_o) rxv_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmi_vld_i & cmi_rdy_o) begin
      rxd_q <= cmi_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_ren_i) begin
      case (reg_adr_i)
        ADR_CFG: reg_rdt_o <= 32'(cfg_o);
        ADR_STS: reg_rdt_o <= {30'd0, rxv_q, busy};
        ADR_DAT: reg_rdt_o <= rxd_q;
        ADR_CTL: reg_rdt_o <= 32'(cmo_o.ctl);
        default: reg_rdt_o <= '0;
      endcase
    end
  end

  // error one cycle after an undefined access
  always_ff @(posedge clk) begin
    if (rst_i) begin
      reg_err_o <= 1'b0;
    end else begin
      reg_err_o <= (reg_wen_i | reg_ren_i) & (reg_adr_i > ADR_CTL);
    end
  end

endmodule

// ==== verilog/spi_rpo.sv ====
/* command to byte queue */
module spi_rpo (
  input  logic            clk,
  input  logic            rst_i,
  // command in
  input  logic            cmd_vld_i,
  input  spi_pkg::cmo_t   cmd_i,
  output logic            cmd_rdy_o,
  // byte queue out
  output logic            que_vld_o,
  output spi_pkg::que_o_t que_o,
  input  logic            que_rdy_i
);

  import spi_pkg::*;

  cmo_t       cmd_q;   // held command
  logic [1:0] idx_q;   // current byte, counts down to 0
  logic       full_q;
  logic       lst;

  assign cmd_rdy_o = ~full_q;  // only when empty
  assign que_vld_o = full_q;
  assign lst       = (idx_q == 2'd0);

  // highest selected byte goes first
  always_comb begin
    que_o.dat = cmd_q.dat[idx_q*SDW +: SDW];
    que_o.iom = cmd_q.ctl.iom;
    que_o.die = cmd_q.ctl.die;
    que_o.ssh = cmd_q.ctl.ssh;
    que_o.lst = lst;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      full_q <= 1'b0;
      idx_q  <= 2'd0;
    end else if (cmd_vld_i & cmd_rdy_o) begin
      full_q <= 1'b1;
      idx_q  <= cmd_i.ctl.cnt;
    end else if (que_vld_o & que_rdy_i) begin
      if (lst) begin
        full_q <= 1'b0;  // bits 7..0 gone
      end else begin
        idx_q <= idx_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_vld_i & cmd_rdy_o) begin
      cmd_q <= cmd_i;
    end
  end

endmodule

// ==== verilog/spi_rpi.sv ====
/* received bytes to word */
module spi_rpi (
  input  logic            clk,
  input  logic            rst_i,
  // byte queue in
  input  logic            que_vld_i,
  input  spi_pkg::que_i_t que_i,
  output logic            que_rdy_o,
  // word out
  output logic            cmd_vld_o,
  output spi_pkg::cmi_t   cmd_o,
  input  logic            cmd_rdy_i
);

  import spi_pkg::*;

  cmi_t word_q;  // assembly word
  logic fst_q;   // next byte opens a command
  logic vld_q;
  logic acc;

  // stall serializer while a finished word is parked
  assign que_rdy_o = ~vld_q;
  assign acc       = que_vld_i & que_rdy_o;
  assign cmd_vld_o = vld_q;
  assign cmd_o     = word_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      fst_q <= 1'b1;
      vld_q <= 1'b0;
    end else begin
      if (vld_q & cmd_rdy_i) vld_q <= 1'b0;
      if (acc) begin
        fst_q <= que_i.lst;
        if (que_i.lst) vld_q <= 1'b1;  // word complete
      end
    end
  end

  // shift in from the right, cleared on first byte
  always_ff @(posedge clk) begin
    if (acc) begin
      if (fst_q) begin
        word_q <= {{(CDW-SDW){1'b0}}, que_i.dat};
      end else begin
        word_q <= {word_q[CDW-SDW-1:0], que_i.dat};
      end
    end
  end

endmodule

// ==== verilog/spi_ser.sv ====
/* SPI serializer, mode 0 */
module spi_ser (
  input  logic                    clk,
  input  logic                    rst_i,
  input  spi_pkg::cfg_t           cfg_i,
  output logic                    busy_o,
  // output byte queue
  input  logic                    quo_vld_i,
  input  spi_pkg::que_o_t         quo_i,
  output logic                    quo_rdy_o,
  // input byte queue
  output logic                    qui_vld_o,
  output spi_pkg::que_i_t         qui_o,
  input  logic                    qui_rdy_i,
  // pins
  output logic                    spi_sclk_o,
  output logic                    spi_sclk_e_o,
  input  logic [3:0]              spi_sio_i,
  output logic [3:0]              spi_sio_o,
  output logic [3:0]              spi_sio_e_o,
  output logic [spi_pkg::SSW-1:0] spi_ss_o,
  output logic [spi_pkg::SSW-1:0] spi_ss_e_o
);

  import spi_pkg::*;

  typedef enum logic [1:0] {ST_IDL, ST_LO, ST_HI, ST_SSD} st_t;

  st_t             st_q;
  logic [DIVW-1:0] div_q;   // half period counter
  logic            tick;    // half period elapsed
  logic [2:0]      bit_q;   // sclk periods left minus one
  logic [SDW-1:0]  tx_q;
  logic [SDW-1:0]  rx_q;
  logic [SDW-1:0]  tx_nxt;
  logic [SDW-1:0]  rx_nxt;
  iom_t            iom_q;
  logic            die_q;
  logic            ssh_q;
  logic            lst_q;
  logic            sclk_q;
  logic [SSW-1:0]  ss_q;
  logic            ld;      // byte taken from queue

  assign tick      = (div_q >= cfg_i.div);
  assign quo_rdy_o = (st_q == ST_IDL) & ~qui_vld_o;  // rx item must be gone first
  assign ld        = quo_vld_i & quo_rdy_o;
  assign busy_o    = quo_vld_i | (st_q != ST_IDL) | qui_vld_o;

  assign spi_sclk_o   = sclk_q;
  assign spi_sclk_e_o = |ss_q;
  assign spi_ss_o     = ss_q;
  assign spi_ss_e_o   = {SSW{|ss_q}};
  assign qui_o.dat    = rx_q;
  assign qui_o.lst    = lst_q;

  // msb first, 1/2/4 bits per sclk period
  always_comb begin
    case (iom_q)
      IOM_SGL: begin
        tx_nxt = {tx_q[SDW-2:0], 1'b0};
        rx_nxt = {rx_q[SDW-2:0], spi_sio_i[1]};  // miso
      end
      IOM_DUA: begin
        tx_nxt = {tx_q[SDW-3:0], 2'b00};
        rx_nxt = {rx_q[SDW-3:0], spi_sio_i[1:0] & {2{die_q}}};
      end
      default: begin  // quad
        tx_nxt = {tx_q[SDW-5:0], 4'h0};
        rx_nxt = {rx_q[SDW-5:0], spi_sio_i & {4{die_q}}};
      end
    endcase
  end

  always_comb begin
    spi_sio_o   = 4'h0;
    spi_sio_e_o = 4'h0;
    case (iom_q)
      IOM_SGL: begin
        spi_sio_o[0] = tx_q[SDW-1];
        spi_sio_e_o  = 4'b0001;  // full duplex always
      end
      IOM_DUA: begin
        spi_sio_o[1:0] = tx_q[SDW-1 -: 2];
        spi_sio_e_o    = {2'b00, {2{~die_q}}};
      end
      default: begin
        spi_sio_o   = tx_q[SDW-1 -: 4];
        spi_sio_e_o = {4{~die_q}};
      end
    endcase
    if (ss_q == '0) spi_sio_e_o = 4'h0;  // bus released when deselected
  end

  ////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      st_q      <= ST_IDL;
      div_q     <= '0;
      bit_q     <= 3'd0;
      tx_q      <= '0;
      iom_q     <= IOM_SGL;
      die_q     <= 1'b0;
      ssh_q     <= 1'b0;
      lst_q     <= 1'b0;
      sclk_q    <= 1'b0;
      ss_q      <= '0;
      qui_vld_o <= 1'b0;
    end else begin
      if (st_q == ST_IDL || tick) begin
        div_q <= '0;
      end else begin
        div_q <= div_q + 1'b1;
      end
      if (qui_vld_o & qui_rdy_i) qui_vld_o <= 1'b0;
      case (st_q)
        ST_IDL: if (ld) begin
          st_q  <= ST_LO;  // data out, select up half period before rise
          tx_q  <= quo_i.dat;
          iom_q <= quo_i.iom;
          die_q <= quo_i.die;
          ssh_q <= quo_i.ssh;
          lst_q <= quo_i.lst;
          bit_q <= (quo_i.iom == IOM_SGL) ? 3'd7 : (quo_i.iom == IOM_DUA) ? 3'd3 : 3'd1;
          ss_q  <= SSW'(1) << cfg_i.ssi;
        end
        ST_LO: if (tick) begin
          st_q   <= ST_HI;
          sclk_q <= 1'b1;  // rising edge, slave samples
        end
        ST_HI: if (tick) begin
          sclk_q <= 1'b0;
          if (bit_q == 3'd0) begin
            qui_vld_o <= 1'b1;  // byte done on last fall
            st_q      <= (lst_q & ~ssh_q) ? ST_SSD : ST_IDL;
          end else begin
            bit_q <= bit_q - 3'd1;
            tx_q  <= tx_nxt;  // change on falling edge
            st_q  <= ST_LO;
          end
        end
        ST_SSD: if (tick) begin
          ss_q <= '0;  // half period after last fall
          st_q <= ST_IDL;
        end
        default: st_q <= ST_IDL;
      endcase
    end
  end

  // capture at the rising edge
  always_ff @(posedge clk) begin
    if (st_q == ST_LO && tick) begin
      rx_q <= rx_nxt;
    end
  end

endmodule

// ==== verilog/spi_master.sv ====
/* SPI master top */
module spi_master (
  input  logic                    clk,
  input  logic                    rst_i,
  // register bus
  input  logic                    reg_wen_i,
  input  logic                    reg_ren_i,
  input  logic [2:0]              reg_adr_i,
  input  logic [31:0]             reg_wdt_i,
  output logic [31:0]             reg_rdt_o,
  output logic                    reg_wrq_o,
  output logic                    reg_err_o,
  output logic                    reg_irq_o,
  // SPI pins
  output logic                    spi_sclk_o,
  output logic                    spi_sclk_e_o,
  input  logic [3:0]              spi_sio_i,
  output logic [3:0]              spi_sio_o,
  output logic [3:0]              spi_sio_e_o,
  output logic [spi_pkg::SSW-1:0] spi_ss_o,
  output logic [spi_pkg::SSW-1:0] spi_ss_e_o
);

  import spi_pkg::*;

  cfg_t   cfg;
  logic   busy;
  logic   cmo_vld;   // regs to rpo
  cmo_t   cmo;
  logic   cmo_rdy;
  logic   quo_vld;   // rpo to ser
  que_o_t quo;
  logic   quo_rdy;
  logic   qui_vld;   // ser to rpi
  que_i_t qui;
  logic   qui_rdy;
  logic   cmi_vld;   // rpi to regs
  cmi_t   cmi;
  logic   cmi_rdy;

  spi_regs regs (
    .clk, .rst_i, .reg_wen_i, .reg_ren_i, .reg_adr_i, .reg_wdt_i,
    .reg_rdt_o, .reg_wrq_o, .reg_err_o, .reg_irq_o,
    .cfg_o (cfg), .busy_i (busy),
    .cmo_vld_o (cmo_vld), .cmo_o (cmo), .cmo_rdy_i (cmo_rdy),
    .cmi_vld_i (cmi_vld), .cmi_i (cmi), .cmi_rdy_o (cmi_rdy)
  );

  spi_rpo rpo (
    .clk, .rst_i,
    .cmd_vld_i (cmo_vld), .cmd_i (cmo), .cmd_rdy_o (cmo_rdy),
    .que_vld_o (quo_vld), .que_o (quo), .que_rdy_i (quo_rdy)
  );

  spi_ser ser (
    .clk, .rst_i, .cfg_i (cfg), .busy_o (busy),
    .quo_vld_i (quo_vld), .quo_i (quo), .quo_rdy_o (quo_rdy),
    .qui_vld_o (qui_vld), .qui_o (qui), .qui_rdy_i (qui_rdy),
    .spi_sclk_o, .spi_sclk_e_o, .spi_sio_i, .spi_sio_o, .spi_sio_e_o,
    .spi_ss_o, .spi_ss_e_o
  );

  spi_rpi rpi (
    .clk, .rst_i,
    .que_vld_i (qui_vld), .que_i (qui), .que_rdy_o (qui_rdy),
    .cmd_vld_o (cmi_vld), .cmd_o (cmi), .cmd_rdy_i (cmi_rdy)
  );

endmodule

// ==== sim/spi_slave_model.sv ====
/* SPI slave model */
module spi_slave_model (
  input  logic          sclk_i,
  input  logic          sel_i,    // own select line
  input  spi_pkg::iom_t iom_i,
  input  logic          ld_i,     // load response, clear capture
  input  logic [31:0]   rsp_i,
  input  logic [3:0]    sio_i,    // bus as the slave sees it
  input  logic [3:0]    sio_e_i,  // master enables
  output logic [3:0]    sio_o,
  output logic [31:0]   cap_o,    // received bits, newest at bit 0
  output int            nbit_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import spi_pkg::*;

  logic [31:0] shf;  // response, next bits at the top

  always_comb begin
    case (iom_i)
      IOM_SGL: sio_o = {2'b00, shf[31], 1'b0};  // miso on sio 1
      IOM_DUA: sio_o = {2'b00, shf[31:30]};
      default: sio_o = shf[31:28];
    endcase
  end

  // next bits go out on the falling edge
  always @(posedge ld_i or negedge sclk_i) begin
    if (ld_i) begin
      shf <= rsp_i;
    end else if (sel_i) begin
      case (iom_i)
        IOM_SGL: shf <= shf << 1;
        IOM_DUA: shf <= shf << 2;
        default: shf <= shf << 4;
      endcase
    end
  end

  // sample at the rising edge, only what the master drives
  always @(posedge ld_i or posedge sclk_i) begin
    if (ld_i) begin
      cap_o  <= '0;
      nbit_o <= 0;
    end else if (sel_i) begin
      if (iom_i == IOM_SGL) begin
        cap_o  <= {cap_o[30:0], sio_i[0]};  // mosi
        nbit_o <= nbit_o + 1;
      end else if (iom_i == IOM_DUA) begin
        if (sio_e_i[1:0] == 2'b11) begin
          cap_o  <= {cap_o[29:0], sio_i[1:0]};
          nbit_o <= nbit_o + 2;
        end
      end else if (sio_e_i == 4'hf) begin
        cap_o  <= {cap_o[27:0], sio_i};
        nbit_o <= nbit_o + 4;
      end
    end
  end

endmodule

// ==== sim/spi_assert.sv ====
/* SPI pin and register checks */
module spi_assert (
  input logic                    clk,
  input logic                    rst_i,
  input spi_pkg::cfg_t           cfg_i,
  input logic                    sclk_i,
  input logic [spi_pkg::SSW-1:0] ss_i,
  input logic [3:0]              sio_e_i,
  input logic                    ren_i,
  input logic [2:0]              adr_i,
  input logic                    irq_i
);
  timeunit 1ns;
  timeprecision 1ps;

  import spi_pkg::*;

  // only the configured select while sclk is high
  a_sel: assert property (@(posedge clk) disable iff (rst_i)
    sclk_i |-> ss_i == (SSW'(1) << cfg_i.ssi)) else $error("select index mismatch");
  // bus direction settles before the rising edge and holds through it
  a_sio_hold: assert property (@(posedge clk) disable iff (rst_i) sclk_i |-> $stable(sio_e_i))
    else $error("sio enables changed while sclk high");
  // reading a waiting word drops the interrupt
  a_irq_clr: assert property (@(posedge clk) disable iff (rst_i)
    ren_i && adr_i == ADR_DAT && irq_i |=> !irq_i) else $error("irq not cleared by data read");

endmodule

// ==== sim/spi_tb.sv ====
/* SPI master testbench */
module spi_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import spi_pkg::*;

  localparam int SEED    = 61526;
  localparam int N_CMD   = 40;
  localparam int LIMIT   = (N_CMD + 8) * 4 * 8 * 2 * 4 + 2000;  // 4 clocks per half period max
  localparam logic [31:0] CFG_MSK = 32'h0000_0fff;  // ien, ssi, div

  logic clk, rst, reg_wen, reg_ren, reg_wrq, reg_err, reg_irq, sclk, sclk_e, slv_ld;
  logic [2:0]     reg_adr, slv_ssi;
  logic [31:0]    reg_wdt, reg_rdt, slv_rsp, slv_cap;
  logic [3:0]     sio_bus, sio_o, sio_e, slv_sio;
  logic [SSW-1:0] ss, ss_e;
  iom_t           slv_iom;
  int             slv_nbit;
  int             cyc = 0;

  spi_master UUT (
    .clk (clk), .rst_i (rst), .reg_wen_i (reg_wen), .reg_ren_i (reg_ren),
    .reg_adr_i (reg_adr), .reg_wdt_i (reg_wdt), .reg_rdt_o (reg_rdt), .reg_wrq_o (reg_wrq),
    .reg_err_o (reg_err), .reg_irq_o (reg_irq), .spi_sclk_o (sclk), .spi_sclk_e_o (sclk_e),
    .spi_sio_i (sio_bus), .spi_sio_o (sio_o), .spi_sio_e_o (sio_e),
    .spi_ss_o (ss), .spi_ss_e_o (ss_e)
  );

  spi_slave_model slave (
    .sclk_i (sclk), .sel_i (ss[slv_ssi]), .iom_i (slv_iom), .ld_i (slv_ld), .rsp_i (slv_rsp),
    .sio_i (sio_bus), .sio_e_i (sio_e), .sio_o (slv_sio), .cap_o (slv_cap), .nbit_o (slv_nbit)
  );

  bind spi_master spi_assert chk (
    .clk (clk), .rst_i (rst_i), .cfg_i (cfg), .sclk_i (spi_sclk_o), .ss_i (spi_ss_o),
    .sio_e_i (spi_sio_e_o), .ren_i (reg_ren_i), .adr_i (reg_adr_i), .irq_i (reg_irq_o)
  );

  assign sio_bus = (sio_e & sio_o) | (~sio_e & slv_sio);  // per-bit tristate

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > LIMIT) fail_now("timeout, the command sequence did not finish");
  end

  ////////////////////////////////////////////////////////////
  // checks and reference
  ////////////////////////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_word(input string name, input cmi_t got, input cmi_t exp);
    if (got !== exp) fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input logic [SDW-1:0] got, exp);
    if (got !== exp) fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // bytes the slave sees, their bit count, and the word read back
  function automatic void ref_model(input logic [1:0] cnt, input iom_t iom, input logic die,
      input logic [31:0] dat, rsp, output logic [31:0] tx, output int nbit, output cmi_t rx);
    logic [31:0] msk;
    msk  = 32'hffff_ffff >> (8 * (3 - int'(cnt)));
    tx   = dat & msk;
    nbit = (iom != IOM_SGL && die) ? 0 : 8 * (int'(cnt) + 1);
    rx   = (iom == IOM_SGL || die) ? (rsp & msk) : '0;  // dual/quad write captures nothing
  endfunction

  ////////////////////////////////////////////////////////////
  // register bus tasks start and end on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic reg_write(input logic [2:0] adr, input logic [31:0] wdt, output int waits);
    logic held;
    waits   = 0;
    reg_wen = 1'b1;
    reg_adr = adr;
    reg_wdt = wdt;
    do begin
      #1 held = reg_wrq;  // settled and stable until the rising edge
      @(negedge clk);
      if (held) waits++;
    end while (held);
    reg_wen = 1'b0;
  endtask

  task automatic reg_read(input logic [2:0] adr, output logic [31:0] rdt);
    reg_ren = 1'b1;
    reg_adr = adr;
    @(negedge clk);
    reg_ren = 1'b0;
    rdt     = reg_rdt;  // one cycle latency
  endtask

  task automatic wait_idle(output logic [31:0] sts);
    do begin
      reg_read(ADR_STS, sts);
    end while (sts[0]);
  endtask

  task automatic wait_rxv();
    logic [31:0] sts;
    do begin
      reg_read(ADR_STS, sts);
    end while (!sts[1]);
  endtask

  task automatic load_slave(input logic [2:0] ssi, input iom_t iom, input logic [31:0] rsp);
    slv_ssi = ssi;
    slv_iom = iom;
    slv_rsp = rsp;
    slv_ld  = 1'b1;
    @(negedge clk);
    slv_ld  = 1'b0;
  endtask

  task automatic run_cmd(input cfg_t cfg, input cmo_ctl_t ctl, input logic [31:0] dat, rsp);
    logic [31:0] exp_tx, rdt;
    cmi_t        exp_rx;
    int          exp_nbit, waits;
    reg_write(ADR_CFG, 32'(cfg), waits);
    load_slave(cfg.ssi, ctl.iom, rsp << (8 * (3 - int'(ctl.cnt))));  // first byte on top
    reg_write(ADR_DAT, dat, waits);
    reg_write(ADR_CTL, 32'(ctl), waits);
    wait_idle(rdt);
    ref_model(ctl.cnt, ctl.iom, ctl.die, dat, rsp, exp_tx, exp_nbit, exp_rx);
    check_bit("sts rxv", rdt[1], 1'b1);
    check_bit("reg_irq_o", reg_irq, cfg.ien);
    for (int i = 0; i < SSW; i++) check_bit("spi_ss_o", ss[i], ctl.ssh && i == int'(cfg.ssi));
    check_word("spi_ss_e_o", 32'(ss_e), 32'({SSW{ctl.ssh}}));  // all ones while held
    check_bit("spi_sclk_e_o", sclk_e, ctl.ssh);
    check_word("slave bit count", 32'(slv_nbit), 32'(exp_nbit));
    for (int i = 0; i < exp_nbit / SDW; i++)
      check_byte("slave byte", slv_cap[i*SDW +: SDW], exp_tx[i*SDW +: SDW]);
    reg_read(ADR_DAT, rdt);
    check_word("reg_rdt_o dat", rdt, exp_rx);
    check_bit("reg_irq_o after read", reg_irq, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and compare
  ////////////////////////////////////////////////////////////

  initial begin
    cfg_t        cfg;
    cmo_ctl_t    ctl;
    logic [31:0] rdt, wdt, rsp;
    logic [31:0] dat [3];
    logic [31:0] tx [3];
    cmi_t        rx [3];
    int          nb, waits;
    void'($urandom(SEED));
    rst     = 1'b1;
    reg_wen = 1'b0;
    reg_ren = 1'b0;
    reg_adr = '0;
    reg_wdt = '0;
    slv_ld  = 1'b0;
    slv_ssi = '0;
    slv_iom = IOM_SGL;
    slv_rsp = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit("spi_sclk_o", sclk, 1'b0);
    check_bit("spi_sclk_e_o", sclk_e, 1'b0);
    check_word("spi_ss_o", 32'(ss), '0);
    check_word("spi_ss_e_o", 32'(ss_e), '0);
    check_word("spi_sio_e_o", 32'(sio_e), '0);
    check_bit("reg_irq_o", reg_irq, 1'b0);
    reg_read(ADR_STS, rdt);
    check_word("reg_rdt_o sts", rdt, '0);

    // cfg read back, then an undefined address
    for (int i = 0; i < 4; i++) begin
      wdt = $urandom;
      reg_write(ADR_CFG, wdt, waits);
      reg_read(ADR_CFG, rdt);
      check_word("reg_rdt_o cfg", rdt, wdt & CFG_MSK);
      check_bit("reg_err_o", reg_err, 1'b0);
    end
    reg_read(3'd5, rdt);
    check_bit("reg_err_o", reg_err, 1'b1);

    // A of 2 bytes then B and C of 1 byte each
    // C's control write has to wait
    cfg = '0;
    cfg.ien = 1'b1;
    cfg.ssi = 3'd2;
    cfg.div = 8'd1;
    reg_write(ADR_CFG, 32'(cfg), waits);
    rsp = $urandom;
    load_slave(3'd2, IOM_SGL, rsp);
    ctl = '0;
    for (int k = 0; k < 3; k++) begin
      dat[k]  = $urandom;
      ctl.cnt = (k == 0) ? 2'd1 : 2'd0;
      reg_write(ADR_DAT, dat[k], waits);
      reg_write(ADR_CTL, 32'(ctl), waits);
    end
    if (waits == 0) fail_now("control write to a pending command was not held");
    ref_model(2'd1, IOM_SGL, 1'b0, dat[0], rsp >> 16, tx[0], nb, rx[0]);
    ref_model(2'd0, IOM_SGL, 1'b0, dat[1], rsp >> 8, tx[1], nb, rx[1]);
    ref_model(2'd0, IOM_SGL, 1'b0, dat[2], rsp, tx[2], nb, rx[2]);
    for (int k = 0; k < 3; k++) begin
      wait_rxv();
      check_bit("reg_irq_o", reg_irq, 1'b1);
      reg_read(ADR_DAT, rdt);
      check_word("reg_rdt_o queued", rdt, rx[k]);
    end
    wait_idle(rdt);
    check_word("slave queued bytes", slv_cap, {tx[0][15:0], tx[1][7:0], tx[2][7:0]});
    check_word("slave bit count", 32'(slv_nbit), 32'd32);

    // random commands over all modes
    ctl = '0;
    for (int n = 0; n < N_CMD; n++) begin
      if (!ctl.ssh) cfg.ssi = 3'($urandom_range(0, 7));  // held select keeps its index
      cfg.div = 8'($urandom_range(0, 3));
      cfg.ien = 1'($urandom);
      ctl.iom = 2'($urandom);
      ctl.die = 1'($urandom);
      ctl.cnt = 2'($urandom);
      ctl.ssh = ($urandom_range(0, 3) == 0);
      run_cmd(cfg, ctl, $urandom, $urandom);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== list.f ====
verilog/spi_pkg.sv
verilog/spi_regs.sv
verilog/spi_rpo.sv
verilog/spi_rpi.sv
verilog/spi_ser.sv
verilog/spi_master.sv
sim/spi_slave_model.sv
sim/spi_assert.sv
sim/spi_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module spi_tb -f list.f -o spi_tb_sim \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/spi_tb_sim 2>&1)"
echo "$out"

echo "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1
